/* rtl/vreadPkg.sv */
package vreadPkg;

   // array size
   localparam int NUM_UNITS = 4;

   // buffer address, top bit picks the ping-pong half
   localparam int ADDR_W = 8;

   // data and external bus widths
   localparam int DATA_W = 32;
   localparam int BUS_ADDR_W = 32;
   localparam int LEN_W = 8;

   // generator count and delay
   localparam int COUNT_W = 8;

   localparam int UNIT_W = $clog2(NUM_UNITS);

   // sum of all lanes needs room for the carries
   localparam int SUM_W = DATA_W + UNIT_W;

   typedef logic [ADDR_W-1:0]     memAddrT;
   typedef logic [DATA_W-1:0]     dataT;
   typedef logic [BUS_ADDR_W-1:0] busAddrT;
   typedef logic [LEN_W-1:0]      lenT;
   typedef logic [COUNT_W-1:0]    countT;
   typedef logic [UNIT_W-1:0]     unitIdxT;
   typedef logic [SUM_W-1:0]      sumT;

   // bus arbiter FSM
   typedef enum logic {
      Idle,
      Burst
   } arbStateT;

endpackage

/* rtl/addressGen.sv */
`timescale 1ns/1ps

module addressGen
   import vreadPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    run,
   input  memAddrT start,
   input  memAddrT incr,
   input  countT   count,
   input  countT   delay,
   input  logic    ready,
   output logic    valid,
   output memAddrT addr,
   output logic    done
);

   logic    busy;
   countT   delayCnt;
   countT   remaining;
   memAddrT incrReg;
   logic    accept;

   // addresses flow once the start delay has run out
   assign valid = busy && (delayCnt == '0);
   assign accept = valid && ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         delayCnt  <= '0;
         remaining <= '0;
         done      <= 1'b0;
      end else begin
         done <= 1'b0;
         if (run) begin
            // a zero count finishes right away
            busy      <= (count != '0);
            delayCnt  <= delay;
            remaining <= count;
            done      <= (count == '0);
         end else if (busy) begin
            if (delayCnt != '0) begin
               delayCnt <= delayCnt - 1'b1;
            end else if (ready) begin
               remaining <= remaining - 1'b1;
               // last handshake, done shows up next cycle
               if (remaining == countT'(1)) begin
                  busy <= 1'b0;
                  done <= 1'b1;
               end
            end
         end
      end
   end

   // address accumulator
   always_ff @(posedge clk) begin
      if (run) begin
         addr    <= start;
         incrReg <= incr;
      end else if (accept) begin
         addr <= addr + incrReg;
      end
   end

endmodule

/* rtl/bufferRam.sv */
`timescale 1ns/1ps

module bufferRam
   import vreadPkg::*;
(
   input  logic    clk,
   input  logic    writeEn,
   input  memAddrT writeAddr,
   input  dataT    writeData,
   input  logic    readEn,
   input  memAddrT readAddr,
   output dataT    readData
);

   localparam int DEPTH = 1 << ADDR_W;

   // both ping-pong halves live in one array
   dataT mem [0:DEPTH-1];

   // write port
   always_ff @(posedge clk) begin
      if (writeEn) begin
         mem[writeAddr] <= writeData;
      end
   end

   // read port, one cycle latency
   always_ff @(posedge clk) begin
      if (readEn) begin
         readData <= mem[readAddr];
      end
   end

endmodule

/* rtl/vectorRead.sv */
`timescale 1ns/1ps

module vectorRead
   import vreadPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    run,
   input  logic    disabled,
   input  busAddrT extAddr,
   input  lenT     fetchLen,
   input  memAddrT fetchIncr,
   input  memAddrT replayStart,
   input  memAddrT replayIncr,
   input  countT   replayCount,
   input  countT   replayDelay,
   input  logic    reverse,
   input  logic    pingPong,
   input  logic    reqReady,
   input  dataT    reqRdata,
   input  logic    reqLast,
   output logic    done,
   output logic    reqValid,
   output busAddrT reqAddr,
   output lenT     reqLen,
   output logic    laneValid,
   output dataT    laneData
);

   localparam int LOW_W = ADDR_W - 1;

   logic    fetchRun;
   logic    fetchDone;
   logic    replayDone;
   logic    pingPongBit;
   logic    writeHalf;
   logic    readHalf;
   logic    fetchValid;
   memAddrT fetchAddr;
   logic    replayValid;
   memAddrT replayAddr;
   logic    replayGenDone;
   logic    beat;
   memAddrT writeAddr;
   memAddrT readAddr;

   function automatic logic [LOW_W-1:0] reverseBits(input logic [LOW_W-1:0] word);
      logic [LOW_W-1:0] res;
      for (int i = 0; i < LOW_W; i++) begin
         res[i] = word[LOW_W-1-i];
      end
      return res;
   endfunction

   // a disabled unit skips the fetch phase
   assign fetchRun = run && !disabled;

   assign done = fetchDone && replayDone;
   assign reqValid = fetchValid && !fetchDone;
   assign beat = reqValid && reqReady;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fetchDone   <= 1'b1;
         replayDone  <= 1'b1;
         pingPongBit <= 1'b0;
      end else if (fetchRun) begin
         fetchDone   <= 1'b0;
         replayDone  <= 1'b0;
         pingPongBit <= pingPong ? !pingPongBit : 1'b0;
      end else begin
         if (beat && reqLast) begin
            fetchDone <= 1'b1;
         end
         if (replayGenDone) begin
            replayDone <= 1'b1;
         end
      end
   end

   // fetch fills the other half while replay drains the current one
   always_ff @(posedge clk) begin
      if (fetchRun) begin
         reqAddr   <= extAddr;
         reqLen    <= fetchLen;
         writeHalf <= pingPong && !pingPongBit;
      end
      if (run) begin
         readHalf <= pingPong && pingPongBit;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         laneValid <= 1'b0;
      end else begin
         laneValid <= replayValid;
      end
   end

   // fetch side, stalled by the bus grant
   addressGen fetchGen (
      .clk   (clk),
      .rst   (rst),
      .run   (fetchRun),
      .start ('0),
      .incr  (fetchIncr),
      .count (countT'(fetchLen)),
      .delay ('0),
      .ready (reqReady),
      .valid (fetchValid),
      .addr  (fetchAddr),
      .done  ()
   );

   // replay side never stalls
   addressGen replayGen (
      .clk   (clk),
      .rst   (rst),
      .run   (run),
      .start ({1'b0, replayStart[LOW_W-1:0]}),
      .incr  (replayIncr),
      .count (replayCount),
      .delay (replayDelay),
      .ready (1'b1),
      .valid (replayValid),
      .addr  (replayAddr),
      .done  (replayGenDone)
   );

   assign writeAddr = {writeHalf, fetchAddr[LOW_W-1:0]};

   // reversal stays inside the half
   assign readAddr = reverse ? {readHalf, reverseBits(replayAddr[LOW_W-1:0])}
                             : {readHalf, replayAddr[LOW_W-1:0]};

   bufferRam buffer (
      .clk       (clk),
      .writeEn   (beat),
      .writeAddr (writeAddr),
      .writeData (reqRdata),
      .readEn    (replayValid),
      .readAddr  (readAddr),
      .readData  (laneData)
   );

endmodule

/* rtl/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter
   import vreadPkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic    [NUM_UNITS-1:0]  reqValid,
   input  busAddrT [NUM_UNITS-1:0]  reqAddr,
   input  lenT     [NUM_UNITS-1:0]  reqLen,
   output logic    [NUM_UNITS-1:0]  reqReady,
   output dataT    [NUM_UNITS-1:0]  reqRdata,
   output logic    [NUM_UNITS-1:0]  reqLast,
   input  logic                     busReady,
   input  dataT                     busRdata,
   input  logic                     busLast,
   output logic                     busValid,
   output busAddrT                  busAddr,
   output lenT                      busLen
);

   arbStateT             state;
   unitIdxT              grant;
   unitIdxT              nextGrant;
   logic                 found;
   logic [NUM_UNITS-1:0] reqMask;
   logic                 beat;

   // search starts after the last winner, the owner is skipped on its final beat
   always_comb begin
      unitIdxT cand;
      reqMask = reqValid;
      if (state == Burst) begin
         reqMask[grant] = 1'b0;
      end
      found = 1'b0;
      nextGrant = grant;
      for (int i = 1; i <= NUM_UNITS; i++) begin
         cand = unitIdxT'((int'(grant) + i) % NUM_UNITS);
         if (!found && reqMask[cand]) begin
            found = 1'b1;
            nextGrant = cand;
         end
      end
   end

   assign busValid = (state == Burst) && reqValid[grant];
   assign busAddr = reqAddr[grant];
   assign busLen = reqLen[grant];
   assign beat = busValid && busReady;

   // only the granted unit sees the bus
   always_comb begin
      reqReady = '0;
      reqRdata = '0;
      reqLast = '0;
      if (state == Burst) begin
         reqReady[grant] = busReady;
         reqRdata[grant] = busRdata;
         reqLast[grant] = busLast;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= Idle;
         grant <= '0;
      end else begin
         case (state)
            Idle: begin
               if (found) begin
                  state <= Burst;
                  grant <= nextGrant;
               end
            end
            Burst: begin
               // hand over straight away when someone is waiting
               if (beat && busLast) begin
                  if (found) begin
                     grant <= nextGrant;
                  end else begin
                     state <= Idle;
                  end
               end
            end
            default: state <= Idle;
         endcase
      end
   end

endmodule

/* rtl/laneCollector.sv */
`timescale 1ns/1ps

module laneCollector
   import vreadPkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic [NUM_UNITS-1:0]  laneValid,
   input  dataT [NUM_UNITS-1:0]  laneData,
   output logic [NUM_UNITS-1:0]  outValid,
   output dataT [NUM_UNITS-1:0]  outData,
   output logic                  sumValid,
   output sumT                   sum
);

   sumT laneSum;

   // add only the lanes valid this cycle
   always_comb begin
      laneSum = '0;
      for (int i = 0; i < NUM_UNITS; i++) begin
         if (laneValid[i]) begin
            laneSum = laneSum + sumT'(laneData[i]);
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         outValid <= '0;
         sumValid <= 1'b0;
      end else begin
         outValid <= laneValid;
         sumValid <= |laneValid;
      end
   end

   // payload lines up with the valids above
   always_ff @(posedge clk) begin
      outData <= laneData;
      sum     <= laneSum;
   end

endmodule

/* rtl/vreadArray.sv */
`timescale 1ns/1ps

module vreadArray
   import vreadPkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,

   // external bus
   output logic                     busValid,
   output busAddrT                  busAddr,
   output lenT                      busLen,
   input  logic                     busReady,
   input  dataT                     busRdata,
   input  logic                     busLast,

   // per-unit configuration
   input  busAddrT [NUM_UNITS-1:0]  extAddr,
   input  lenT     [NUM_UNITS-1:0]  fetchLen,
   input  memAddrT [NUM_UNITS-1:0]  fetchIncr,
   input  memAddrT [NUM_UNITS-1:0]  replayStart,
   input  memAddrT [NUM_UNITS-1:0]  replayIncr,
   input  countT   [NUM_UNITS-1:0]  replayCount,
   input  countT   [NUM_UNITS-1:0]  replayDelay,
   input  logic    [NUM_UNITS-1:0]  reverse,
   input  logic    [NUM_UNITS-1:0]  pingPong,
   input  logic    [NUM_UNITS-1:0]  disabled,

   // collected streams
   output logic    [NUM_UNITS-1:0]  outValid,
   output dataT    [NUM_UNITS-1:0]  outData,
   output logic                     sumValid,
   output sumT                      sum,
   output logic                     allDone
);

   logic    [NUM_UNITS-1:0] reqValid;
   busAddrT [NUM_UNITS-1:0] reqAddr;
   lenT     [NUM_UNITS-1:0] reqLen;
   logic    [NUM_UNITS-1:0] reqReady;
   dataT    [NUM_UNITS-1:0] reqRdata;
   logic    [NUM_UNITS-1:0] reqLast;
   logic    [NUM_UNITS-1:0] laneValid;
   dataT    [NUM_UNITS-1:0] laneData;
   logic    [NUM_UNITS-1:0] unitDone;

   assign allDone = &unitDone;

   busArbiter arbiter (
      .clk      (clk),
      .rst      (rst),
      .reqValid (reqValid),
      .reqAddr  (reqAddr),
      .reqLen   (reqLen),
      .reqReady (reqReady),
      .reqRdata (reqRdata),
      .reqLast  (reqLast),
      .busReady (busReady),
      .busRdata (busRdata),
      .busLast  (busLast),
      .busValid (busValid),
      .busAddr  (busAddr),
      .busLen   (busLen)
   );

   for (genvar u = 0; u < NUM_UNITS; u++) begin : genUnit
      vectorRead unit (
         .clk         (clk),
         .rst         (rst),
         .run         (run),
         .disabled    (disabled[u]),
         .extAddr     (extAddr[u]),
         .fetchLen    (fetchLen[u]),
         .fetchIncr   (fetchIncr[u]),
         .replayStart (replayStart[u]),
         .replayIncr  (replayIncr[u]),
         .replayCount (replayCount[u]),
         .replayDelay (replayDelay[u]),
         .reverse     (reverse[u]),
         .pingPong    (pingPong[u]),
         .reqReady    (reqReady[u]),
         .reqRdata    (reqRdata[u]),
         .reqLast     (reqLast[u]),
         .done        (unitDone[u]),
         .reqValid    (reqValid[u]),
         .reqAddr     (reqAddr[u]),
         .reqLen      (reqLen[u]),
         .laneValid   (laneValid[u]),
         .laneData    (laneData[u])
      );
   end

   laneCollector collector (
      .clk       (clk),
      .rst       (rst),
      .laneValid (laneValid),
      .laneData  (laneData),
      .outValid  (outValid),
      .outData   (outData),
      .sumValid  (sumValid),
      .sum       (sum)
   );

endmodule

/* tb/busMemModel.sv */
`timescale 1ns/1ps

module busMemModel
   import vreadPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    busValid,
   input  busAddrT busAddr,
   input  lenT     busLen,
   output logic    busReady,
   output dataT    busRdata,
   output logic    busLast
);

   integer seed = 50;
   lenT    beatIdx;
   logic   beat;

   assign beat = busValid && busReady;

   // each beat returns its own byte address, scrambled
   assign busRdata = dataT'((busAddr + busAddrT'(beatIdx) * 4) ^ 32'hA5A50000);

   // beats are numbered from zero, so the final one is busLen - 1
   assign busLast = busValid && (beatIdx == lenT'(busLen - 1'b1));

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         busReady <= 1'b0;
         beatIdx  <= '0;
      end else begin
         // stall about one cycle in four
         busReady <= (($random(seed) & 3) != 0);
         if (beat) begin
            if (busLast) begin
               beatIdx <= '0;
            end else begin
               beatIdx <= beatIdx + 1'b1;
            end
         end
      end
   end

endmodule

/* tb/vreadArrayTb.sv */
`timescale 1ns/1ps

module vreadArrayTb
   import vreadPkg::*;
;

   localparam int NUM_RUNS = 4;
   localparam int IDX_W = ADDR_W - 1;

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    run;
   logic                    busValid;
   busAddrT                 busAddr;
   lenT                     busLen;
   logic                    busReady;
   dataT                    busRdata;
   logic                    busLast;
   busAddrT [NUM_UNITS-1:0] extAddr;
   lenT     [NUM_UNITS-1:0] fetchLen;
   memAddrT [NUM_UNITS-1:0] fetchIncr;
   memAddrT [NUM_UNITS-1:0] replayStart;
   memAddrT [NUM_UNITS-1:0] replayIncr;
   countT   [NUM_UNITS-1:0] replayCount;
   countT   [NUM_UNITS-1:0] replayDelay;
   logic    [NUM_UNITS-1:0] reverse;
   logic    [NUM_UNITS-1:0] pingPong;
   logic    [NUM_UNITS-1:0] disabled;
   logic    [NUM_UNITS-1:0] outValid;
   dataT    [NUM_UNITS-1:0] outData;
   logic                    sumValid;
   sumT                     sum;
   logic                    allDone;

   // reference model of the buffers
   dataT                 refMem [NUM_UNITS][0:255];
   dataT                 expWords [NUM_UNITS][0:255];
   int                   expCount [NUM_UNITS];
   logic [NUM_UNITS-1:0] ppBit;
   integer               seed;

   // monitor state
   int                   outCount [NUM_UNITS];
   int                   bursts [NUM_UNITS];
   logic [NUM_UNITS-1:0] firstSeen;
   int                   cycleNo;
   int                   runCycle;
   logic                 runSeen;
   logic                 prevAllDone;
   logic                 burstOpen;
   int                   burstOwner;

   always #4 clk = ~clk;

   vreadArray DUT (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .busValid    (busValid),
      .busAddr     (busAddr),
      .busLen      (busLen),
      .busReady    (busReady),
      .busRdata    (busRdata),
      .busLast     (busLast),
      .extAddr     (extAddr),
      .fetchLen    (fetchLen),
      .fetchIncr   (fetchIncr),
      .replayStart (replayStart),
      .replayIncr  (replayIncr),
      .replayCount (replayCount),
      .replayDelay (replayDelay),
      .reverse     (reverse),
      .pingPong    (pingPong),
      .disabled    (disabled),
      .outValid    (outValid),
      .outData     (outData),
      .sumValid    (sumValid),
      .sum         (sum),
      .allDone     (allDone)
   );

   busMemModel memModel (
      .clk      (clk),
      .rst      (rst),
      .busValid (busValid),
      .busAddr  (busAddr),
      .busLen   (busLen),
      .busReady (busReady),
      .busRdata (busRdata),
      .busLast  (busLast)
   );

   task stopOnFailure;
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task reportMismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      stopOnFailure();
   endtask

   task reportFailure(input string msg);
      $display("%s", msg);
      stopOnFailure();
   endtask

   // index with its bits in reverse order
   function automatic logic [IDX_W-1:0] mirrorIndex(input logic [IDX_W-1:0] idx);
      logic [IDX_W-1:0] res;
      res = '0;
      for (int i = 0; i < IDX_W; i++) begin
         res = {res[IDX_W-2:0], idx[i]};
      end
      return res;
   endfunction

   always @(posedge clk) begin : monitor
      sumT        expSum;
      logic       found;
      int         owner;
      if (rst) begin
         cycleNo     <= 0;
         runCycle    <= 0;
         runSeen     <= 1'b0;
         prevAllDone <= 1'b1;
         burstOpen   <= 1'b0;
         burstOwner  <= 0;
         firstSeen   <= '0;
         for (int u = 0; u < NUM_UNITS; u++) begin
            outCount[u] <= 0;
            bursts[u]   <= 0;
         end
      end else begin
         cycleNo     <= cycleNo + 1;
         runSeen     <= run;
         prevAllDone <= allDone;
         if (run) begin
            runCycle  <= cycleNo;
            firstSeen <= '0;
            for (int u = 0; u < NUM_UNITS; u++) begin
               outCount[u] <= 0;
               bursts[u]   <= 0;
            end
         end
         if (runSeen) begin
            assert (allDone === 1'b0) else reportMismatch("allDone", allDone, 0);
         end

         // replay words against the reference buffers
         expSum = '0;
         for (int u = 0; u < NUM_UNITS; u++) begin
            if (outValid[u]) begin
               assert (outCount[u] < expCount[u])
                  else reportFailure($sformatf("unit %0d produced too many replay words", u));
               assert (outData[u] === expWords[u][outCount[u]])
                  else reportMismatch($sformatf("outData[%0d]", u), outData[u],
                                      expWords[u][outCount[u]]);
               // generator delay, buffer read, then collector register
               if (!firstSeen[u]) begin
                  assert (cycleNo - runCycle == int'(replayDelay[u]) + 3)
                     else reportMismatch($sformatf("first outValid[%0d] latency", u),
                                         cycleNo - runCycle, int'(replayDelay[u]) + 3);
               end
               firstSeen[u] <= 1'b1;
               outCount[u]  <= outCount[u] + 1;
               expSum = expSum + sumT'(expWords[u][outCount[u]]);
            end
         end
         assert (sumValid === |outValid) else reportMismatch("sumValid", sumValid, |outValid);
         if (sumValid) begin
            assert (sum === expSum) else reportMismatch("sum", sum, expSum);
         end

         // allDone must wait for every enabled unit
         if (allDone && !prevAllDone) begin
            for (int u = 0; u < NUM_UNITS; u++) begin
               if (!disabled[u]) begin
                  assert (bursts[u] == 1)
                     else reportFailure($sformatf("allDone rose before unit %0d fetched", u));
                  assert (outCount[u] + int'(outValid[u]) == expCount[u])
                     else reportFailure($sformatf("allDone rose before unit %0d replayed", u));
               end
            end
         end

         // owner of each burst found by its address
         if (busValid && busReady) begin
            owner = burstOwner;
            if (!burstOpen) begin
               found = 1'b0;
               for (int u = 0; u < NUM_UNITS; u++) begin
                  if (extAddr[u] === busAddr) begin
                     found = 1'b1;
                     owner = u;
                  end
               end
               assert (found && !disabled[owner])
                  else reportFailure("bus burst does not belong to an enabled unit");
               assert (bursts[owner] == 0)
                  else reportFailure($sformatf("unit %0d got a second burst in one run", owner));
               burstOwner <= owner;
            end
            assert (busAddr === extAddr[owner])
               else reportMismatch("busAddr", busAddr, extAddr[owner]);
            assert (busLen === fetchLen[owner])
               else reportMismatch("busLen", busLen, fetchLen[owner]);
            burstOpen <= !busLast;
            if (busLast) begin
               bursts[owner] <= bursts[owner] + 1;
            end
         end
      end
   end

   task startRun(input int r);
      busAddrT          base;
      lenT              len;
      memAddrT          step;
      memAddrT          rStart;
      memAddrT          rStep;
      countT            rCount;
      countT            rDelay;
      logic             rev;
      logic             off;
      logic [IDX_W-1:0] idx;
      @(posedge clk);
      for (int u = 0; u < NUM_UNITS; u++) begin
         base   = busAddrT'(32'h10000 * (r + 1) + 32'h1000 * u);
         // odd step and at least 128 beats fill the whole half
         len    = lenT'(128 + ($random(seed) & 63));
         step   = memAddrT'((($random(seed) & 31) << 1) | 1);
         rStart = memAddrT'($random(seed) & 255);
         rStep  = memAddrT'(1 + ($random(seed) & 3));
         rDelay = countT'($random(seed) & 15);
         rCount = (r == 0) ? countT'(0) : countT'(1 + ($random(seed) & 31));
         rev    = (r >= 2) ? (($random(seed) & 1) == 1) : 1'b0;
         off    = (r == 2) && (u == 1);

         // replay drains the half filled by the previous run
         for (int j = 0; j < int'(rCount); j++) begin
            idx = IDX_W'((int'(rStart) + j * int'(rStep)) % (1 << IDX_W));
            if (rev) begin
               idx = mirrorIndex(idx);
            end
            expWords[u][j] = refMem[u][{ppBit[u], idx}];
         end
         expCount[u] = int'(rCount);
         if (!off) begin
            for (int k = 0; k < int'(len); k++) begin
               idx = IDX_W'((k * int'(step)) % (1 << IDX_W));
               refMem[u][{!ppBit[u], idx}] = dataT'((base + busAddrT'(4 * k)) ^ 32'hA5A50000);
            end
            ppBit[u] = !ppBit[u];
         end

         extAddr[u]     <= base;
         fetchLen[u]    <= len;
         fetchIncr[u]   <= step;
         replayStart[u] <= rStart;
         replayIncr[u]  <= rStep;
         replayCount[u] <= rCount;
         replayDelay[u] <= rDelay;
         reverse[u]     <= rev;
         disabled[u]    <= off;
      end
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
   endtask

   task waitRunDone;
      logic settled;
      settled = 1'b0;
      while (!settled) begin
         @(posedge clk);
         settled = allDone;
         for (int u = 0; u < NUM_UNITS; u++) begin
            if (outCount[u] != expCount[u]) begin
               settled = 1'b0;
            end
         end
      end
      for (int u = 0; u < NUM_UNITS; u++) begin
         assert (bursts[u] == (disabled[u] ? 0 : 1))
            else reportMismatch($sformatf("bursts[%0d]", u), bursts[u], disabled[u] ? 0 : 1);
      end
   endtask

   initial begin
      seed        = 50;
      ppBit       = '0;
      rst         <= 1'b1;
      run         <= 1'b0;
      extAddr     <= '0;
      fetchLen    <= '0;
      fetchIncr   <= '0;
      replayStart <= '0;
      replayIncr  <= '0;
      replayCount <= '0;
      replayDelay <= '0;
      reverse     <= '0;
      pingPong    <= '1;
      disabled    <= '0;
      for (int u = 0; u < NUM_UNITS; u++) begin
         expCount[u] = 0;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // idle outputs straight after reset
      assert (allDone === 1'b1) else reportMismatch("allDone", allDone, 1);
      assert (outValid === '0) else reportMismatch("outValid", outValid, 0);
      assert (sumValid === 1'b0) else reportMismatch("sumValid", sumValid, 0);
      assert (busValid === 1'b0) else reportMismatch("busValid", busValid, 0);

      for (int r = 0; r < NUM_RUNS; r++) begin
         startRun(r);
         waitRunDone();
      end
      repeat (4) @(posedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

   // generous bound per run
   initial begin
      repeat (NUM_RUNS * 2000) @(posedge clk);
      reportFailure("timeout: a run did not finish in time");
   end

endmodule

/* vreadArray.f */
rtl/vreadPkg.sv
rtl/addressGen.sv
rtl/bufferRam.sv
rtl/vectorRead.sv
rtl/busArbiter.sv
rtl/laneCollector.sv
rtl/vreadArray.sv
tb/busMemModel.sv
tb/vreadArrayTb.sv

/* Bender.yml */
package:
  name: vread_array

sources:
  - files:
      - rtl/vreadPkg.sv
      - rtl/addressGen.sv
      - rtl/bufferRam.sv
      - rtl/vectorRead.sv
      - rtl/busArbiter.sv
      - rtl/laneCollector.sv
      - rtl/vreadArray.sv
  - target: test
    files:
      - tb/busMemModel.sv
      - tb/vreadArrayTb.sv
